// File: design/alu32.sv
`timescale 1ns/100ps

`include "exStage_macros.svh"

module alu32 import exStagePkg::*; (
  input  aluFuncT                          aluFunc,
  input  logic [`DATA_WIDTH-1:0]           a,
  input  logic [`DATA_WIDTH-1:0]           b,
  input  logic [$clog2(`DATA_WIDTH)-1:0]   shamt,
  output logic [`DATA_WIDTH-1:0]           result,
  output logic                             zero
);

  logic [`DATA_WIDTH-1:0] sum;
  logic [`DATA_WIDTH-1:0] diff;
  logic                   lessThan;

  assign sum  = a + b;
  assign diff = a - b;

  // signed compare for slt / slti
  assign lessThan = $signed(a) < $signed(b);

  always_comb begin
    case (aluFunc)
      aluAnd: begin
        result = a & b;
      end
      aluOr: begin
        result = a | b;
      end
      aluAdd: begin
        result = sum;
      end
      aluSub: begin
        result = diff;
      end
      aluSlt: begin
        result = {{(`DATA_WIDTH-1){1'b0}}, lessThan};
      end
      aluNor: begin
        result = ~(a | b);
      end
      aluXor: begin
        result = a ^ b;
      end
      // shifts act on the second operand, as in MIPS
      aluSll: begin
        result = b << shamt;
      end
      aluSrl: begin
        result = b >> shamt;
      end
      default: begin
        result = sum;
      end
    endcase
  end

  // zero drives the beq decision downstream
  assign zero = (result == '0);

endmodule

// File: design/aluControl.sv
`timescale 1ns/100ps

`include "exStage_macros.svh"

module aluControl import exStagePkg::*; (
  input  aluOpT                   aluOp,
  input  logic [`OPCODE_WIDTH-1:0] funct,
  output aluFuncT                 aluFunc
);

  // R-type funct codes
  localparam logic [`OPCODE_WIDTH-1:0] FunctSll = 6'h00;
  localparam logic [`OPCODE_WIDTH-1:0] FunctSrl = 6'h02;
  localparam logic [`OPCODE_WIDTH-1:0] FunctAdd = 6'h20;
  localparam logic [`OPCODE_WIDTH-1:0] FunctSub = 6'h22;
  localparam logic [`OPCODE_WIDTH-1:0] FunctAnd = 6'h24;
  localparam logic [`OPCODE_WIDTH-1:0] FunctOr  = 6'h25;
  localparam logic [`OPCODE_WIDTH-1:0] FunctXor = 6'h26;
  localparam logic [`OPCODE_WIDTH-1:0] FunctNor = 6'h27;
  localparam logic [`OPCODE_WIDTH-1:0] FunctSlt = 6'h2A;

  aluFuncT rtypeFunc;

  // funct decode, only meaningful for R-type
  always_comb begin
    case (funct)
      FunctAdd: rtypeFunc = aluAdd;
      FunctSub: rtypeFunc = aluSub;
      FunctAnd: rtypeFunc = aluAnd;
      FunctOr:  rtypeFunc = aluOr;
      FunctXor: rtypeFunc = aluXor;
      FunctNor: rtypeFunc = aluNor;
      FunctSlt: rtypeFunc = aluSlt;
      FunctSll: rtypeFunc = aluSll;
      FunctSrl: rtypeFunc = aluSrl;
      default:  rtypeFunc = aluAdd;
    endcase
  end

  always_comb begin
    case (aluOp)
      opRtype: aluFunc = rtypeFunc;
      // address calculation for memory ops
      opAddi,
      opLw,
      opSw:    aluFunc = aluAdd;
      opAndi:  aluFunc = aluAnd;
      opOri:   aluFunc = aluOr;
      opSlti:  aluFunc = aluSlt;
      // beq compares by subtracting
      opBeq:   aluFunc = aluSub;
      default: aluFunc = aluAdd;
    endcase
  end

endmodule

// File: design/exStagePkg.sv
`include "exStage_macros.svh"

package exStagePkg;

  // main opcode values as they appear in the instruction word
  typedef enum logic [`OPCODE_WIDTH-1:0] {
    opRtype = 6'h00,
    opBeq   = 6'h04,
    opAddi  = 6'h08,
    opSlti  = 6'h0A,
    opAndi  = 6'h0C,
    opOri   = 6'h0D,
    opLw    = 6'h23,
    opSw    = 6'h2B
  } aluOpT;

  // operation selected inside the ALU
  typedef enum logic [3:0] {
    aluAnd = 4'b0000,
    aluOr  = 4'b0001,
    aluAdd = 4'b0010,
    aluXor = 4'b0011,
    aluSub = 4'b0110,
    aluSlt = 4'b0111,
    aluSll = 4'b1000,
    aluSrl = 4'b1001,
    aluNor = 4'b1100
  } aluFuncT;

  // control bits produced by decode
  typedef struct packed {
    logic regWrite;
    logic memToReg;
    logic branch;
    logic memRead;
    logic memWrite;
    logic regDst;
    logic aluSrc;
  } ctrlT;

  // ID/EX pipeline register contents
  typedef struct packed {
    ctrlT                       ctrl;
    aluOpT                      aluOp;
    logic [`DATA_WIDTH-1:0]     pcPlus4;
    logic [`DATA_WIDTH-1:0]     readData1;
    logic [`DATA_WIDTH-1:0]     readData2;
    logic [`DATA_WIDTH-1:0]     signExt;
    logic [`REG_ADDR_WIDTH-1:0] rt;
    logic [`REG_ADDR_WIDTH-1:0] rd;
  } idExT;

  // EX/MEM pipeline register contents, regDst and aluSrc are consumed here
  typedef struct packed {
    logic                       regWrite;
    logic                       memToReg;
    logic                       branch;
    logic                       memRead;
    logic                       memWrite;
    logic [`DATA_WIDTH-1:0]     branchTarget;
    logic                       zero;
    logic [`DATA_WIDTH-1:0]     aluResult;
    logic [`DATA_WIDTH-1:0]     readData2;
    logic [`REG_ADDR_WIDTH-1:0] writeReg;
  } exMemT;

endpackage

// File: design/exStage_macros.svh
`ifndef EXSTAGE_MACROS_SVH
`define EXSTAGE_MACROS_SVH

// datapath width of the pipeline
`define DATA_WIDTH 32

// register number, rt / rd / writeReg
`define REG_ADDR_WIDTH 5

// main opcode field, the funct field has the same width
`define OPCODE_WIDTH 6

`endif

// File: design/executeUnit.sv
`timescale 1ns/100ps

`include "exStage_macros.svh"

module executeUnit import exStagePkg::*; (
  input  logic  Clk,
  input  logic  reset,
  input  idExT  idExIn,
  output exMemT exMemOut
);

  // ID/EX register output
  idExT  idExQ;

  // combinational result of the execute stage
  exMemT exMemD;

  // both registers load every cycle, no stall path

  always_ff @(posedge Clk) begin
    if (reset) begin
      idExQ <= '0;
    end else begin
      idExQ <= idExIn;
    end
  end

  stageEx stageEx_i (
    .idEx  (idExQ),
    .exMem (exMemD)
  );

  // EX/MEM register, clearing it also clears the memory control bits
  always_ff @(posedge Clk) begin
    if (reset) begin
      exMemOut <= '0;
    end else begin
      exMemOut <= exMemD;
    end
  end

endmodule

// File: design/stageEx.sv
`timescale 1ns/100ps

`include "exStage_macros.svh"

module stageEx import exStagePkg::*; (
  input  idExT  idEx,
  output exMemT exMem
);

  aluFuncT                     aluFunc;
  logic [`DATA_WIDTH-1:0]      aluB;
  logic [`DATA_WIDTH-1:0]      aluResult;
  logic                        zero;
  logic [`DATA_WIDTH-1:0]      branchTarget;
  logic [`REG_ADDR_WIDTH-1:0]  writeReg;

  // second operand, immediate when aluSrc is set
  assign aluB = idEx.ctrl.aluSrc ? idEx.signExt : idEx.readData2;

  // destination register, rd for R-type
  assign writeReg = idEx.ctrl.regDst ? idEx.rd : idEx.rt;

  // word offset to byte offset, relative to PC+4
  assign branchTarget = idEx.pcPlus4 + (idEx.signExt << 2);

  // funct sits in the low bits of the sign-extended immediate
  aluControl aluControl_i (
    .aluOp   (idEx.aluOp),
    .funct   (idEx.signExt[`OPCODE_WIDTH-1:0]),
    .aluFunc (aluFunc)
  );

  alu32 alu32_i (
    .aluFunc (aluFunc),
    .a       (idEx.readData1),
    .b       (aluB),
    .shamt   (idEx.signExt[10:6]),
    .result  (aluResult),
    .zero    (zero)
  );

  always_comb begin
    exMem.regWrite     = idEx.ctrl.regWrite;
    exMem.memToReg     = idEx.ctrl.memToReg;
    exMem.branch       = idEx.ctrl.branch;
    exMem.memRead      = idEx.ctrl.memRead;
    exMem.memWrite     = idEx.ctrl.memWrite;
    exMem.branchTarget = branchTarget;
    exMem.zero         = zero;
    exMem.aluResult    = aluResult;
    // store data goes to memory untouched
    exMem.readData2    = idEx.readData2;
    exMem.writeReg     = writeReg;
  end

endmodule

// File: run.sh
#!/bin/sh
# builds and runs the execute unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary -f vlog.f --top-module executeUnitTb -Mdir obj_dir -o simExecuteUnit
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

./obj_dir/simExecuteUnit > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# the log decides the result
if grep -q "Verification passed" sim.log; then
  exit 0
fi
exit 1

// File: verif/exStage_testdata.txt
// in:  ctrl aluOp pcPlus4 readData1 readData2 signExt rt rd
// out: memCtrl branchTarget zero aluResult readData2 writeReg
42 00 00000004 00000005 00000003 00000020 02 03  10 00000084 0 00000008 00000003 03 // add
42 00 00000008 0000000a 0000000a 00000022 04 05  10 00000090 1 00000000 0000000a 05 // sub, zero
42 00 0000000c 00000003 00000005 00000022 06 07  10 00000094 0 fffffffe 00000005 07 // sub
42 00 00000010 ff00ff00 0f0f0f0f 00000024 01 08  10 000000a0 0 0f000f00 0f0f0f0f 08 // and
42 00 00000014 ff00ff00 0f0f0f0f 00000025 01 09  10 000000a8 0 ff0fff0f 0f0f0f0f 09 // or
42 00 00000018 ff00ff00 0f0f0f0f 00000026 01 0a  10 000000b0 0 f00ff00f 0f0f0f0f 0a // xor
42 00 0000001c 00ff00ff 0000ffff 00000027 01 0b  10 000000b8 0 ff000000 0000ffff 0b // nor
42 00 00000020 fffffffb fffffffe 0000002a 01 0c  10 000000c8 0 00000001 fffffffe 0c // slt -5 < -2
42 00 00000024 00000007 fffffff0 0000002a 01 0d  10 000000cc 1 00000000 fffffff0 0d // slt 7 < -16
42 00 00000028 12345678 00000001 00000100 01 0e  10 00000428 0 00000010 00000001 0e // sll by 4
42 00 0000002c 12345678 80000000 000007c2 01 0f  10 00001f34 0 00000001 80000000 0f // srl by 31
42 00 0000004c 7fffffff 00000001 00000020 1e 1f  10 000000cc 0 80000000 00000001 1f // add wraps
41 08 00000030 00000010 deadbeef fffffffc 10 11  10 00000020 0 0000000c deadbeef 10 // addi -4
41 0c 00000034 12345678 00000000 0000ff00 12 13  10 0003fc34 0 00005600 00000000 12 // andi
41 0d 00000038 12340000 00000000 00005678 14 15  10 00015a18 0 12345678 00000000 14 // ori
41 0a 0000003c fffffff6 00000000 00000005 16 17  10 00000050 0 00000001 00000000 16 // slti
69 23 00000040 10000000 0000abcd 00000010 08 00  1a 00000080 0 10000010 0000abcd 08 // lw
69 23 00000044 10000100 00000000 fffffff8 09 00  1a 00000024 0 100000f8 00000000 09 // lw -8
05 2b 00000048 10000000 cafef00d 00000024 0a 00  01 000000d8 0 10000024 cafef00d 0a // sw
10 04 00001000 00000042 00000042 00000010 03 00  04 00001040 1 00000000 00000042 03 // beq taken
10 04 00002000 00000001 00000002 fffffff0 04 00  04 00001fc0 0 ffffffff 00000002 04 // beq back
10 04 00000100 80000000 80000000 ffffff00 05 00  04 fffffd00 1 00000000 80000000 05 // beq wraps

// File: verif/executeUnitTb.sv
`timescale 1ns/100ps

`include "exStage_macros.svh"

module executeUnitTb import exStagePkg::*; ();

  localparam int NumVectors     = 22;
  localparam int WordsPerVector = 14;
  localparam int NumWords       = NumVectors * WordsPerVector;
  // reset, vectors, two cycles of drain, then margin
  localparam int TimeoutCycles  = 10 + NumVectors + 2 + 20;

  logic  Clk;
  logic  reset;
  idExT  idExIn;
  exMemT exMemOut;

  // one vector is 8 input words followed by 6 expected words
  logic [`DATA_WIDTH-1:0] vecMem [0:NumWords-1];

  // expected results in flight, entry 1 is due at the current falling edge
  exMemT expPipe  [0:1];
  logic  expValid [0:1];
  int    expIndex [0:1];

  int errorCount;
  int checkCount;
  int cycleCount;

  executeUnit dut_i (
    .Clk      (Clk),
    .reset    (reset),
    .idExIn   (idExIn),
    .exMemOut (exMemOut)
  );

  initial Clk = 1'b0;
  always #50 Clk = ~Clk;

  task automatic checkValue(input string name, input logic [`DATA_WIDTH-1:0] actual,
                            input logic [`DATA_WIDTH-1:0] expected);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("ERROR %0t: %s actual %h expected %h", $time, name, actual, expected);
    end
  endtask

  function automatic idExT vectorInput(input int idx);
    idExT v;
    int   base;
    base        = idx * WordsPerVector;
    v.ctrl      = vecMem[base][6:0];
    v.aluOp     = aluOpT'(vecMem[base+1][`OPCODE_WIDTH-1:0]);
    v.pcPlus4   = vecMem[base+2];
    v.readData1 = vecMem[base+3];
    v.readData2 = vecMem[base+4];
    v.signExt   = vecMem[base+5];
    v.rt        = vecMem[base+6][`REG_ADDR_WIDTH-1:0];
    v.rd        = vecMem[base+7][`REG_ADDR_WIDTH-1:0];
    return v;
  endfunction

  // memory control word is regWrite memToReg branch memRead memWrite, msb first
  function automatic exMemT vectorExpected(input int idx);
    exMemT e;
    int    base;
    base           = idx * WordsPerVector + 8;
    e.regWrite     = vecMem[base][4];
    e.memToReg     = vecMem[base][3];
    e.branch       = vecMem[base][2];
    e.memRead      = vecMem[base][1];
    e.memWrite     = vecMem[base][0];
    e.branchTarget = vecMem[base+1];
    e.zero         = vecMem[base+2][0];
    e.aluResult    = vecMem[base+3];
    e.readData2    = vecMem[base+4];
    e.writeReg     = vecMem[base+5][`REG_ADDR_WIDTH-1:0];
    return e;
  endfunction

  task automatic compareOutput(input exMemT e, input int idx);
    string tag;
    tag = $sformatf("vec%0d.", idx);
    checkValue({tag, "regWrite"}, 32'(exMemOut.regWrite), 32'(e.regWrite));
    checkValue({tag, "memToReg"}, 32'(exMemOut.memToReg), 32'(e.memToReg));
    checkValue({tag, "branch"}, 32'(exMemOut.branch), 32'(e.branch));
    checkValue({tag, "memRead"}, 32'(exMemOut.memRead), 32'(e.memRead));
    checkValue({tag, "memWrite"}, 32'(exMemOut.memWrite), 32'(e.memWrite));
    checkValue({tag, "branchTarget"}, exMemOut.branchTarget, e.branchTarget);
    checkValue({tag, "zero"}, 32'(exMemOut.zero), 32'(e.zero));
    checkValue({tag, "aluResult"}, exMemOut.aluResult, e.aluResult);
    checkValue({tag, "readData2"}, exMemOut.readData2, e.readData2);
    checkValue({tag, "writeReg"}, 32'(exMemOut.writeReg), 32'(e.writeReg));
  endtask

  always @(posedge Clk) begin
    cycleCount++;
    if (cycleCount > TimeoutCycles) begin
      $display("timeout: run did not finish within %0d cycles", TimeoutCycles);
      $display("Verification failed");
      $finish;
    end
  end

  initial begin
    reset       = 1'b1;
    idExIn      = '0;
    // decode presents live control bits while reset is held
    idExIn.ctrl = '1;
    errorCount  = 0;
    checkCount  = 0;
    cycleCount  = 0;
    for (int i = 0; i < 2; i++) begin
      expPipe[i]  = '0;
      expValid[i] = 1'b0;
      expIndex[i] = 0;
    end
    // words left over by a short file keep their address-dependent fill
    for (int i = 0; i < NumWords; i++) begin
      vecMem[i] = 32'hdead0000 | i;
    end
    $readmemh("verif/exStage_testdata.txt", vecMem);
    if (vecMem[NumWords-1][`DATA_WIDTH-1:`REG_ADDR_WIDTH] != '0) begin
      $display("data file holds fewer than %0d vectors", NumVectors);
      errorCount++;
    end

    repeat (10) @(posedge Clk);
    @(negedge Clk);
    // nothing may write memory or the register file straight after reset
    checkValue("reset.regWrite", 32'(exMemOut.regWrite), 32'd0);
    checkValue("reset.memToReg", 32'(exMemOut.memToReg), 32'd0);
    checkValue("reset.branch", 32'(exMemOut.branch), 32'd0);
    checkValue("reset.memRead", 32'(exMemOut.memRead), 32'd0);
    checkValue("reset.memWrite", 32'(exMemOut.memWrite), 32'd0);
    reset = 1'b0;

    for (int k = 0; k < NumVectors + 2; k++) begin
      if (k > 0) begin
        @(negedge Clk);
      end
      if (expValid[1]) begin
        compareOutput(expPipe[1], expIndex[1]);
      end
      expPipe[1]  = expPipe[0];
      expValid[1] = expValid[0];
      expIndex[1] = expIndex[0];
      if (k < NumVectors) begin
        idExIn      = vectorInput(k);
        expPipe[0]  = vectorExpected(k);
        expValid[0] = 1'b1;
        expIndex[0] = k;
      end else begin
        // bubbles while the last two vectors drain
        idExIn      = '0;
        expValid[0] = 1'b0;
      end
    end

    $display("checks: %0d  errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: vlog.f
+incdir+design
design/exStagePkg.sv
design/aluControl.sv
design/alu32.sv
design/stageEx.sv
design/executeUnit.sv
verif/executeUnitTb.sv
